// ==== logic/led_matrix_settings.svh ====
/* panel geometry and BCM timing for the 16x8 HUB75 driver
   the package widths follow these values, so change them together */
`ifndef LED_MATRIX_SETTINGS_SVH
`define LED_MATRIX_SETTINGS_SVH

// panel size, scanned as two halves of LM_ROWS/2 lines
`define LM_COLS 16
`define LM_ROWS 8

// bits per colour channel, one bit plane each
`define LM_PLANES 4

// enable cycles of plane 0, doubled for every higher plane
`define LM_BASE_DISPLAY 4

`endif

// ==== logic/matrix_geometry_pkg.sv ====
/* address and counter types for panel geometry and scan position
   widths derive from the settings header */
`include "led_matrix_settings.svh"

package matrix_geometry_pkg;

    typedef logic [$clog2(`LM_COLS)-1:0] col_addr_t;
    typedef logic [$clog2(`LM_ROWS/2)-1:0] line_addr_t; // also the panel row address
    typedef logic half_t; // 0 top, 1 bottom
    typedef logic [$clog2(`LM_PLANES)-1:0] plane_t;

    // framebuffer word address, line in the upper bits
    typedef logic [$bits(line_addr_t)+$bits(col_addr_t)-1:0] pair_addr_t;

    // wide enough for the longest plane period
    typedef logic [$clog2(`LM_BASE_DISPLAY << (`LM_PLANES-1)):0] display_count_t;

endpackage

// ==== logic/pixel_format_pkg.sv ====
/* colour, pixel, command and panel signal types
   byte encodings of the host commands live here */
`include "led_matrix_settings.svh"

package pixel_format_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [`LM_PLANES-1:0] channel_t;
    typedef logic [`LM_PLANES-1:0] plane_mask_t; // bit p enables plane p

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } pixel_t;

    // one framebuffer word feeds both halves
    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_signals_t;

    typedef struct packed {
        logic                            valid;
        matrix_geometry_pkg::half_t      half;
        matrix_geometry_pkg::pair_addr_t addr;
        pixel_t                          pixel;
    } fb_write_t;

    typedef enum logic [7:0] {
        CMD_PIXEL    = 8'h50,
        CMD_PLANES   = 8'h42,
        CMD_CHANNELS = 8'h43
    } cmd_t;

    typedef enum logic [2:0] {
        PS_CMD,
        PS_ADDR,
        PS_RED,
        PS_GREEN_BLUE,
        PS_PLANES,
        PS_CHANNELS
    } parser_state_t;

    typedef enum logic [1:0] {
        SHIFT,
        LATCH,
        DISPLAY
    } scan_state_t;

    typedef struct packed {
        rgb_signals_t                    rgb_top;
        rgb_signals_t                    rgb_bottom;
        matrix_geometry_pkg::line_addr_t row_addr;
        logic                            pixel_clk;
        logic                            latch;
        logic                            oe_n;
    } hub75_t;

endpackage

// ==== logic/command_parser.sv ====
`timescale 1ns/1ps
/* four-phase byte port, one byte per req pulse, ack held until req drops
   unknown command bytes are acknowledged and dropped */
module command_parser (
    input  logic                        clk_root,
    input  logic                        rst_n,
    input  pixel_format_pkg::byte_t     host_byte,
    input  logic                        host_req,
    output logic                        host_ack,
    output pixel_format_pkg::fb_write_t fb_write,
    output logic                        planes_wr,
    output logic                        channels_wr,
    output pixel_format_pkg::byte_t     settings_value
);

    pixel_format_pkg::parser_state_t state;
    logic                            take;
    logic                            wr_valid;
    matrix_geometry_pkg::half_t      wr_half;
    matrix_geometry_pkg::pair_addr_t wr_addr;
    pixel_format_pkg::pixel_t        wr_pixel;

    assign take = host_req && !host_ack; // new byte on the port
    assign fb_write = '{valid: wr_valid, half: wr_half, addr: wr_addr, pixel: wr_pixel};

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            host_ack <= 1'b0;
        end else if (take) begin
            host_ack <= 1'b1;
        end else if (!host_req) begin
            host_ack <= 1'b0; // req seen low, close the cycle
        end
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state       <= pixel_format_pkg::PS_CMD;
            wr_valid    <= 1'b0;
            planes_wr   <= 1'b0;
            channels_wr <= 1'b0;
        end else begin
            wr_valid    <= 1'b0; // all strobes are single cycle
            planes_wr   <= 1'b0;
            channels_wr <= 1'b0;
            if (take) begin
                case (state)
                    pixel_format_pkg::PS_CMD: begin
                        case (pixel_format_pkg::cmd_t'(host_byte))
                            pixel_format_pkg::CMD_PIXEL:    state <= pixel_format_pkg::PS_ADDR;
                            pixel_format_pkg::CMD_PLANES:   state <= pixel_format_pkg::PS_PLANES;
                            pixel_format_pkg::CMD_CHANNELS: state <= pixel_format_pkg::PS_CHANNELS;
                            default:                        state <= pixel_format_pkg::PS_CMD;
                        endcase
                    end
                    pixel_format_pkg::PS_ADDR:       state <= pixel_format_pkg::PS_RED;
                    pixel_format_pkg::PS_RED:        state <= pixel_format_pkg::PS_GREEN_BLUE;
                    pixel_format_pkg::PS_GREEN_BLUE: begin
                        wr_valid <= 1'b1;
                        state    <= pixel_format_pkg::PS_CMD;
                    end
                    pixel_format_pkg::PS_PLANES: begin
                        planes_wr <= 1'b1;
                        state     <= pixel_format_pkg::PS_CMD;
                    end
                    pixel_format_pkg::PS_CHANNELS: begin
                        channels_wr <= 1'b1;
                        state       <= pixel_format_pkg::PS_CMD;
                    end
                    default: state <= pixel_format_pkg::PS_CMD;
                endcase
            end
        end
    end

    // payload capture, fields only change while no strobe is pending
    always_ff @(posedge clk_root) begin
        if (take) begin
            case (state)
                pixel_format_pkg::PS_ADDR: begin
                    wr_half <= host_byte[6];   // rows 4..7 are the bottom half
                    wr_addr <= host_byte[5:0]; // line in 5:4, column in 3:0
                end
                pixel_format_pkg::PS_RED: begin
                    wr_pixel.red <= host_byte[3:0];
                end
                pixel_format_pkg::PS_GREEN_BLUE: begin
                    wr_pixel.green <= host_byte[7:4];
                    wr_pixel.blue  <= host_byte[3:0];
                end
                pixel_format_pkg::PS_PLANES, pixel_format_pkg::PS_CHANNELS: begin
                    settings_value <= host_byte;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/display_settings.sv ====
`timescale 1ns/1ps
/* plane and channel enable registers, all ones after reset
   strobes come already decoded from the parser */
module display_settings (
    input  logic                          clk_root,
    input  logic                          rst_n,
    input  logic                          planes_wr,
    input  logic                          channels_wr,
    input  pixel_format_pkg::byte_t       settings_value,
    output pixel_format_pkg::plane_mask_t plane_enable,
    output pixel_format_pkg::rgb_signals_t channel_enable
);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            plane_enable   <= '1; // everything visible
            channel_enable <= '1;
        end else begin
            if (planes_wr) begin
                plane_enable <= settings_value[$bits(pixel_format_pkg::plane_mask_t)-1:0];
            end
            if (channels_wr) begin
                // red in bit 2, blue in bit 0
                channel_enable <= pixel_format_pkg::rgb_signals_t'(settings_value[2:0]);
            end
        end
    end

endmodule

// ==== logic/frame_buffer.sv ====
`timescale 1ns/1ps
/* pixel-pair memory, contents undefined until written
   one cycle read latency, a write touches only the named half */
module frame_buffer (
    input  logic                            clk_root,
    input  pixel_format_pkg::fb_write_t     fb_write,
    input  matrix_geometry_pkg::pair_addr_t read_addr,
    output pixel_format_pkg::pixel_pair_t   read_data
);

    localparam int DEPTH = 2 ** $bits(matrix_geometry_pkg::pair_addr_t);

    pixel_format_pkg::pixel_pair_t mem [DEPTH];

    always_ff @(posedge clk_root) begin
        if (fb_write.valid) begin
            if (fb_write.half) begin
                mem[fb_write.addr].bottom <= fb_write.pixel;
            end else begin
                mem[fb_write.addr].top <= fb_write.pixel;
            end
        end
    end

    always_ff @(posedge clk_root) begin
        read_data <= mem[read_addr]; // scan side
    end

endmodule

// ==== logic/matrix_scan.sv ====
`timescale 1ns/1ps
/* line/plane scan with binary-weighted enable time
   pixel_clk trails read_addr by two cycles to match memory and output registers */
`include "led_matrix_settings.svh"

module matrix_scan (
    input  logic                            clk_root,
    input  logic                            rst_n,
    output matrix_geometry_pkg::pair_addr_t read_addr,
    output matrix_geometry_pkg::plane_t     plane,
    output logic                            pixel_clk,
    output logic                            latch,
    output logic                            oe_n,
    output matrix_geometry_pkg::line_addr_t row_addr
);

    localparam int SHIFT_LEN = 2 * `LM_COLS + 2; // two cycles per column plus drain

    pixel_format_pkg::scan_state_t       state;
    logic [$clog2(SHIFT_LEN)-1:0]        shift_step;
    matrix_geometry_pkg::col_addr_t      col;
    matrix_geometry_pkg::line_addr_t     line;
    matrix_geometry_pkg::plane_t         cur_plane;
    matrix_geometry_pkg::display_count_t display_cnt;
    matrix_geometry_pkg::display_count_t display_len;
    logic                                clk_raw;
    logic                                clk_pipe;

    assign col = matrix_geometry_pkg::col_addr_t'(shift_step >> 1);
    assign read_addr = {line, col};
    // second cycle of each column, before the drain
    assign clk_raw = (state == pixel_format_pkg::SHIFT) && shift_step[0]
                     && (shift_step < 2 * `LM_COLS);
    assign display_len = matrix_geometry_pkg::display_count_t'(`LM_BASE_DISPLAY) << cur_plane;

    assign latch = (state == pixel_format_pkg::LATCH);
    assign oe_n  = (state != pixel_format_pkg::DISPLAY);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            clk_pipe  <= 1'b0;
            pixel_clk <= 1'b0;
            plane     <= '0;
        end else begin
            clk_pipe  <= clk_raw; // memory stage
            pixel_clk <= clk_pipe; // output register stage
            plane     <= cur_plane; // aligned with read_data
        end
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state       <= pixel_format_pkg::SHIFT;
            shift_step  <= '0;
            display_cnt <= '0;
            line        <= '0;
            cur_plane   <= '0;
            row_addr    <= '0;
        end else begin
            case (state)
                pixel_format_pkg::SHIFT: begin
                    if (shift_step == SHIFT_LEN - 1) begin
                        shift_step <= '0;
                        row_addr   <= line; // visible together with latch
                        state      <= pixel_format_pkg::LATCH;
                    end else begin
                        shift_step <= shift_step + 1'b1;
                    end
                end
                pixel_format_pkg::LATCH: begin
                    display_cnt <= '0;
                    state       <= pixel_format_pkg::DISPLAY;
                end
                pixel_format_pkg::DISPLAY: begin
                    if (display_cnt == display_len - 1'b1) begin
                        cur_plane <= cur_plane + 1'b1; // wraps to plane 0
                        if (cur_plane == matrix_geometry_pkg::plane_t'(`LM_PLANES - 1)) begin
                            line <= line + 1'b1; // wraps after the last line
                        end
                        state <= pixel_format_pkg::SHIFT;
                    end else begin
                        display_cnt <= display_cnt + 1'b1;
                    end
                end
                default: state <= pixel_format_pkg::SHIFT;
            endcase
        end
    end

endmodule

// ==== logic/pixel_output.sv ====
`timescale 1ns/1ps
/* plane bit select and masking for both halves, one register stage
   expects plane already delayed to line up with pair */
module pixel_output (
    input  logic                           clk_root,
    input  logic                           rst_n,
    input  pixel_format_pkg::pixel_pair_t  pair,
    input  matrix_geometry_pkg::plane_t    plane,
    input  pixel_format_pkg::plane_mask_t  plane_enable,
    input  pixel_format_pkg::rgb_signals_t channel_enable,
    output pixel_format_pkg::rgb_signals_t rgb_top,
    output pixel_format_pkg::rgb_signals_t rgb_bottom
);

    pixel_format_pkg::rgb_signals_t bit_mask;

    // channel mask, cleared completely for a disabled plane
    assign bit_mask = channel_enable & {3{plane_enable[plane]}};

    function automatic pixel_format_pkg::rgb_signals_t plane_bits(
        input pixel_format_pkg::pixel_t px
    );
        pixel_format_pkg::rgb_signals_t bits;
        bits.red   = px.red[plane];
        bits.green = px.green[plane];
        bits.blue  = px.blue[plane];
        return pixel_format_pkg::rgb_signals_t'(bits & bit_mask);
    endfunction

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            rgb_top    <= plane_bits(pair.top);
            rgb_bottom <= plane_bits(pair.bottom);
        end
    end

endmodule

// ==== logic/led_matrix_top.sv ====
`timescale 1ns/1ps
/* HUB75 driver top, single clock domain
   panel pins come out as one hub75_t bundle */
module led_matrix_top (
    input  logic                    clk_root,
    input  logic                    rst_n,
    input  pixel_format_pkg::byte_t host_byte,
    input  logic                    host_req,
    output logic                    host_ack,
    output pixel_format_pkg::hub75_t panel
);

    pixel_format_pkg::fb_write_t     fb_write;
    logic                            planes_wr;
    logic                            channels_wr;
    pixel_format_pkg::byte_t         settings_value;
    pixel_format_pkg::plane_mask_t   plane_enable;
    pixel_format_pkg::rgb_signals_t  channel_enable;
    matrix_geometry_pkg::pair_addr_t read_addr;
    pixel_format_pkg::pixel_pair_t   read_data;
    matrix_geometry_pkg::plane_t     plane;

    command_parser u_parser (
        .clk_root, .rst_n, .host_byte, .host_req, .host_ack,
        .fb_write, .planes_wr, .channels_wr, .settings_value
    );

    display_settings u_settings (
        .clk_root, .rst_n, .planes_wr, .channels_wr, .settings_value,
        .plane_enable, .channel_enable
    );

    frame_buffer u_fb (
        .clk_root, .fb_write, .read_addr, .read_data
    );

    matrix_scan u_scan (
        .clk_root, .rst_n, .read_addr, .plane,
        .pixel_clk (panel.pixel_clk),
        .latch     (panel.latch),
        .oe_n      (panel.oe_n),
        .row_addr  (panel.row_addr)
    );

    pixel_output u_pixel (
        .clk_root, .rst_n, .pair (read_data), .plane, .plane_enable, .channel_enable,
        .rgb_top    (panel.rgb_top),
        .rgb_bottom (panel.rgb_bottom)
    );

endmodule

// ==== tb/hub75_panel_model.sv ====
`timescale 1ns/1ps
/* passive HUB75 panel, data is taken on the clock edge that ends each pixel_clk high cycle
   a latched line is reported once its enable period is over */
`include "led_matrix_settings.svh"

module hub75_panel_model (
    input  logic                                          clk_root,
    input  logic                                          rst_n,
    input  pixel_format_pkg::hub75_t                      panel,
    output logic                                          report,
    output matrix_geometry_pkg::line_addr_t               report_row,
    output matrix_geometry_pkg::plane_t                   report_plane,
    output int                                            report_cycles,
    output int                                            report_shifts,
    output pixel_format_pkg::rgb_signals_t [`LM_COLS-1:0] report_top,
    output pixel_format_pkg::rgb_signals_t [`LM_COLS-1:0] report_bottom
);

    pixel_format_pkg::rgb_signals_t [`LM_COLS-1:0] shift_top;
    pixel_format_pkg::rgb_signals_t [`LM_COLS-1:0] shift_bottom;
    int   shift_count;
    int   oe_cycles;
    logic shown; // latched line waiting for its enable period

    // plane index as log2 of the multiple of the base time
    function automatic matrix_geometry_pkg::plane_t plane_of(input int cycles);
        return matrix_geometry_pkg::plane_t'($clog2(cycles / `LM_BASE_DISPLAY));
    endfunction

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            report        <= 1'b0;
            report_row    <= '0;
            report_plane  <= '0;
            report_cycles <= 0;
            report_shifts <= 0;
            report_top    <= '0;
            report_bottom <= '0;
            shift_top     <= '0;
            shift_bottom  <= '0;
            shift_count   <= 0;
            oe_cycles     <= 0;
            shown         <= 1'b0;
        end else begin
            report <= 1'b0;
            if (panel.pixel_clk) begin
                // first column shifted ends up at index 0
                shift_top    <= {panel.rgb_top, shift_top[`LM_COLS-1:1]};
                shift_bottom <= {panel.rgb_bottom, shift_bottom[`LM_COLS-1:1]};
                shift_count  <= shift_count + 1;
            end
            if (panel.latch) begin
                report_top    <= shift_top;
                report_bottom <= shift_bottom;
                report_row    <= panel.row_addr;
                report_shifts <= shift_count;
                shift_count   <= 0;
                oe_cycles     <= 0;
                shown         <= 1'b1;
            end else if (!panel.oe_n) begin
                oe_cycles <= oe_cycles + 1;
            end else if (shown && oe_cycles > 0) begin
                report        <= 1'b1; // enable period just ended
                report_cycles <= oe_cycles;
                report_plane  <= plane_of(oe_cycles);
                shown         <= 1'b0;
            end
        end
    end

endmodule

// ==== tb/led_matrix_tb.sv ====
`timescale 1ns/1ps
/* host byte driver with an image and settings model, checks every latched line
   data is only compared on frames that start after the last write */
`include "led_matrix_settings.svh"

module led_matrix_tb;

    localparam int TIMEOUT_CYCLES = 20000; // ~10 frames of 800 cycles plus ~520 bytes
    localparam int FRAME_LINES = `LM_ROWS / 2 * `LM_PLANES;

    logic                                          clk_root;
    logic                                          rst_n;
    pixel_format_pkg::byte_t                       host_byte;
    logic                                          host_req;
    logic                                          host_ack;
    pixel_format_pkg::hub75_t                      panel;
    logic                                          report;
    matrix_geometry_pkg::line_addr_t               report_row;
    matrix_geometry_pkg::plane_t                   report_plane;
    int                                            report_cycles;
    int                                            report_shifts;
    pixel_format_pkg::rgb_signals_t [`LM_COLS-1:0] report_top;
    pixel_format_pkg::rgb_signals_t [`LM_COLS-1:0] report_bottom;

    pixel_format_pkg::pixel_t       image [`LM_ROWS][`LM_COLS];
    pixel_format_pkg::plane_mask_t  plane_model;
    pixel_format_pkg::rgb_signals_t channel_model;
    matrix_geometry_pkg::line_addr_t exp_line;
    matrix_geometry_pkg::plane_t    exp_plane;
    logic writes_done;
    logic data_on;
    logic ack_prev;
    logic req_prev;
    int   latches_seen;
    int   data_reports;
    int   timing_checks = 0;
    int   errors = 0;
    int   cycles = 0;

    led_matrix_top UUT (
        .clk_root, .rst_n, .host_byte, .host_req, .host_ack, .panel
    );

    hub75_panel_model u_panel (
        .clk_root, .rst_n, .panel, .report, .report_row, .report_plane,
        .report_cycles, .report_shifts, .report_top, .report_bottom
    );

    initial begin
        clk_root = 1'b0;
        forever #20 clk_root = ~clk_root;
    end

    task automatic mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    endtask

    task automatic problem(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    // one four-phase transfer, req held a random number of extra cycles
    task automatic send_byte(input pixel_format_pkg::byte_t value);
        int hold;
        hold = $urandom_range(3, 0);
        host_byte <= value;
        host_req  <= 1'b1;
        @(posedge clk_root);
        while (!host_ack) begin
            @(posedge clk_root);
        end
        repeat (hold) @(posedge clk_root);
        host_req <= 1'b0;
        @(posedge clk_root);
        while (host_ack) begin
            @(posedge clk_root);
        end
    endtask

    task automatic write_pixel(input int row, input int col, input pixel_format_pkg::pixel_t px);
        send_byte(pixel_format_pkg::CMD_PIXEL);
        send_byte({1'b0, 3'(row), 4'(col)});
        send_byte({4'($urandom), px.red}); // high nibble is ignored
        send_byte({px.green, px.blue});
        image[row][col] = px;
    endtask

    task automatic set_display_mask(input pixel_format_pkg::cmd_t cmd,
                                    input pixel_format_pkg::byte_t value);
        send_byte(cmd);
        send_byte(value);
        if (cmd == pixel_format_pkg::CMD_PLANES) begin
            plane_model = value[`LM_PLANES-1:0];
        end else begin
            channel_model = value[2:0];
        end
    endtask

    // lets the checker arm, then waits for one full checked frame
    task automatic wait_for_frame();
        int target;
        writes_done <= 1'b1;
        target = data_reports + FRAME_LINES;
        while (data_reports < target) begin
            @(posedge clk_root);
        end
        writes_done <= 1'b0;
    endtask

    task automatic check_idle();
        assert (panel.oe_n == 1'b1) else mismatch("reset oe_n", 1, panel.oe_n);
        assert (panel.latch == 1'b0) else mismatch("reset latch", 0, panel.latch);
        assert (panel.pixel_clk == 1'b0) else mismatch("reset pixel_clk", 0, panel.pixel_clk);
        assert (host_ack == 1'b0) else mismatch("reset host_ack", 0, host_ack);
    endtask

    function automatic pixel_format_pkg::rgb_signals_t expected_bits(
        input pixel_format_pkg::pixel_t px,
        input matrix_geometry_pkg::plane_t p
    );
        pixel_format_pkg::rgb_signals_t bits;
        bits.red   = px.red[p] & channel_model.red & plane_model[p];
        bits.green = px.green[p] & channel_model.green & plane_model[p];
        bits.blue  = px.blue[p] & channel_model.blue & plane_model[p];
        return bits;
    endfunction

    task automatic check_timing();
        timing_checks++;
        assert (report_row == exp_line) else mismatch("scan line", exp_line, report_row);
        assert (report_plane == exp_plane) else mismatch("plane order", exp_plane, report_plane);
        assert (report_cycles == (`LM_BASE_DISPLAY << exp_plane))
            else mismatch("oe_n low cycles", `LM_BASE_DISPLAY << exp_plane, report_cycles);
        assert (report_shifts == `LM_COLS)
            else mismatch("pixel_clk pulses", `LM_COLS, report_shifts);
    endtask

    task automatic compare_columns();
        pixel_format_pkg::rgb_signals_t exp_top;
        pixel_format_pkg::rgb_signals_t exp_bottom;
        for (int c = 0; c < `LM_COLS; c++) begin
            exp_top    = expected_bits(image[report_row][c], report_plane);
            exp_bottom = expected_bits(image[report_row + `LM_ROWS/2][c], report_plane);
            assert (report_top[c] == exp_top)
                else mismatch($sformatf("top line %0d col %0d", report_row, c),
                              exp_top, report_top[c]);
            assert (report_bottom[c] == exp_bottom)
                else mismatch($sformatf("bottom line %0d col %0d", report_row, c),
                              exp_bottom, report_bottom[c]);
        end
    endtask

    always @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            ack_prev     <= 1'b0;
            req_prev     <= 1'b0;
            exp_line     <= '0;
            exp_plane    <= '0;
            latches_seen <= 0;
            data_on      <= 1'b0;
            data_reports <= 0;
        end else begin
            ack_prev <= host_ack;
            req_prev <= host_req;
            assert (!(host_ack && !ack_prev) || req_prev)
                else problem("host_ack rose while host_req was low");
            assert (!(!host_ack && ack_prev) || !req_prev)
                else problem("host_ack fell while host_req was still high");
            // two latches after the writes, so the next shift is clean
            if (!writes_done) begin
                latches_seen <= 0;
                data_on      <= 1'b0;
            end else if (panel.latch && latches_seen < 2) begin
                latches_seen <= latches_seen + 1;
            end
            if (report) begin
                check_timing();
                exp_plane <= exp_plane + 1'b1;
                if (exp_plane == matrix_geometry_pkg::plane_t'(`LM_PLANES - 1)) begin
                    exp_line <= exp_line + 1'b1;
                end
                if (writes_done && (data_on || (latches_seen == 2 && report_row == '0
                                                && report_plane == '0))) begin
                    data_on <= 1'b1;
                    compare_columns();
                    data_reports <= data_reports + 1;
                end
            end
        end
    end

    task automatic print_summary();
        $display("summary: %0d errors, %0d timing checks, %0d lines data checked",
                 errors, timing_checks, data_reports);
    endtask

    always @(posedge clk_root) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            problem($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
            print_summary();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(62));
        rst_n         = 1'b0;
        host_byte     = '0;
        host_req      = 1'b0;
        writes_done   = 1'b0;
        plane_model   = '1; // reset values of the settings block
        channel_model = '1;
        repeat (4) @(posedge clk_root);
        check_idle();
        rst_n <= 1'b1;
        @(posedge clk_root);
        send_byte(8'hA5); // unknown command, dropped
        for (int r = 0; r < `LM_ROWS; r++) begin
            for (int c = 0; c < `LM_COLS; c++) begin
                write_pixel(r, c, pixel_format_pkg::pixel_t'($urandom));
            end
        end
        wait_for_frame();
        set_display_mask(pixel_format_pkg::CMD_PLANES, 8'h0A);  // planes 1 and 3 only
        set_display_mask(pixel_format_pkg::CMD_CHANNELS, 8'h05); // green off
        wait_for_frame();
        print_summary();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/matrix_geometry_pkg.sv
logic/pixel_format_pkg.sv
logic/command_parser.sv
logic/display_settings.sv
logic/frame_buffer.sv
logic/matrix_scan.sv
logic/pixel_output.sv
logic/led_matrix_top.sv
tb/hub75_panel_model.sv
tb/led_matrix_tb.sv

// ==== Bender.yml ====
package:
  name: led_matrix

sources:
  - include_dirs:
      - logic
    files:
      - logic/matrix_geometry_pkg.sv
      - logic/pixel_format_pkg.sv
      - logic/command_parser.sv
      - logic/display_settings.sv
      - logic/frame_buffer.sv
      - logic/matrix_scan.sv
      - logic/pixel_output.sv
      - logic/led_matrix_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/hub75_panel_model.sv
      - tb/led_matrix_tb.sv
